// File: design/fpExecPkg.sv
package fpExecPkg;

    localparam int EXEC_DEPTH_DEFAULT = 3;

    // Canonical quiet NaN for every NaN result
    localparam logic [31:0] CANONICAL_NAN = 32'h7fc00000;

    // Invalid-operation bit of the five exception flags
    localparam logic [4:0] FLAG_INVALID = 5'b10000;

    typedef enum logic [3:0] {
        FC_ADD,
        FC_SUB,
        FC_MUL,
        FC_SGNJ,
        FC_SGNJN,
        FC_SGNJX,
        FC_MIN,
        FC_MAX,
        FC_FEQ,
        FC_FLT,
        FC_FLE
    } fpuCode;

    typedef enum logic [1:0] {
        UNIT_ADDER,
        UNIT_MULTIPLIER,
        UNIT_MISC
    } fpUnitSel;

    // Active-list position, wraps around
    typedef logic [5:0] robTag;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } fpOperand;

    typedef struct packed {
        logic     valid;
        robTag    tag;
        fpuCode   code;
        logic     srcRegA;
        logic     srcRegB;
        logic     bypassA;
        logic     bypassB;
        fpOperand operandA;
        fpOperand operandB;
    } fpIssueEntry;

    // Valid must stay the top field, the delay line clears that bit on flush
    typedef struct packed {
        logic   valid;
        logic   regValid;
        robTag  tag;
        fpuCode code;
    } fpTagEntry;

    typedef struct packed {
        logic        valid;
        robTag       tag;
        fpuCode      code;
        logic [31:0] data;
        logic [4:0]  flags;
    } fpExecResult;

    typedef struct packed {
        logic  active;
        logic  flushAll;
        robTag headTag;
        robTag tailTag;
    } fpRecovery;

    function automatic fpUnitSel unitOf(fpuCode code);
        case (code)
            FC_ADD, FC_SUB: return UNIT_ADDER;
            FC_MUL:         return UNIT_MULTIPLIER;
            default:        return UNIT_MISC;
        endcase
    endfunction

endpackage

// File: design/fpDelayLine.sv
`timescale 1ns/1ps

module fpDelayLine #(
    parameter type payloadT = logic,
    parameter int  DEPTH    = 1
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             hold,
    input  logic [DEPTH-1:0] flushStage,
    input  payloadT          din,
    output payloadT          stageOut [DEPTH]
);
    // The valid field sits in the top bit of the payload
    localparam int VALID_BIT = $bits(payloadT) - 1;

    payloadT shiftIn [DEPTH];

    always_comb begin
        shiftIn[0] = din;
        for (int i = 1; i < DEPTH; i++) begin
            shiftIn[i] = stageOut[i-1];
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (flushStage[i]) begin
                shiftIn[i][VALID_BIT] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                stageOut[i] <= '0;
            end
        end else if (!hold) begin
            stageOut <= shiftIn;
        end
    end

endmodule

// File: design/fpAdder.sv
`timescale 1ns/1ps

module fpAdder import fpExecPkg::*; #(
    parameter int DEPTH = EXEC_DEPTH_DEFAULT
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        hold,
    input  logic [31:0] lhs,
    input  logic [31:0] rhs,
    input  logic        subtract,
    output logic [31:0] sum
);
    // Aligned sum with carry, hidden bit at 26 and guard/round/sticky below
    typedef struct packed {
        logic        special;
        logic [31:0] specialVal;
        logic        sign;
        logic [7:0]  exp;
        logic [27:0] mant;
    } addStageT;

    function automatic logic [4:0] leadZeros(logic [26:0] v);
        logic [4:0] n;
        n = 5'd27;
        for (int i = 0; i < 27; i++) begin
            if (v[i]) begin
                n = 5'(26 - i);
            end
        end
        return n;
    endfunction

    addStageT    front;
    addStageT    stages [DEPTH-1];
    addStageT    back;

    logic        signA, signB, signBig, signSmall, swap;
    logic        nanA, nanB, infA, infB, sticky;
    logic [7:0]  expA, expB, shift;
    logic [23:0] mantA, mantB;
    logic [26:0] smallExt, alignedSmall;
    logic [27:0] mantBig, raw;

    always_comb begin
        signA = lhs[31];
        signB = rhs[31] ^ subtract;
        expA  = lhs[30:23];
        expB  = rhs[30:23];
        // Subnormal inputs read as zero
        mantA = (expA == 8'd0) ? 24'd0 : {1'b1, lhs[22:0]};
        mantB = (expB == 8'd0) ? 24'd0 : {1'b1, rhs[22:0]};
        nanA  = (expA == 8'hff) && (lhs[22:0] != 23'd0);
        nanB  = (expB == 8'hff) && (rhs[22:0] != 23'd0);
        infA  = (expA == 8'hff) && (lhs[22:0] == 23'd0);
        infB  = (expB == 8'hff) && (rhs[22:0] == 23'd0);

        // Larger magnitude goes first
        swap      = {expB, mantB} > {expA, mantA};
        shift     = swap ? expB - expA : expA - expB;
        signBig   = swap ? signB : signA;
        signSmall = swap ? signA : signB;
        mantBig   = {1'b0, (swap ? mantB : mantA), 3'b000};
        smallExt  = {(swap ? mantA : mantB), 3'b000};

        if (shift >= 8'd27) begin
            alignedSmall = 27'd0;
            sticky       = |smallExt;
        end else begin
            alignedSmall = smallExt >> shift;
            sticky       = |(smallExt & ((27'd1 << shift) - 27'd1));
        end
        alignedSmall[0] = alignedSmall[0] | sticky;

        if (signBig == signSmall) begin
            raw = mantBig + {1'b0, alignedSmall};
        end else begin
            raw = mantBig - {1'b0, alignedSmall};
        end

        front.special = nanA || nanB || infA || infB;
        if (nanA || nanB || (infA && infB && (signA != signB))) begin
            front.specialVal = CANONICAL_NAN;
        end else if (infA) begin
            front.specialVal = {signA, 8'hff, 23'd0};
        end else begin
            front.specialVal = {signB, 8'hff, 23'd0};
        end
        // Exact cancellation gives +0 unless both are -0
        front.sign = (raw == 28'd0) ? (signBig & signSmall) : signBig;
        front.exp  = swap ? expB : expA;
        front.mant = raw;
    end

    fpDelayLine #(
        .payloadT (addStageT),
        .DEPTH    (DEPTH - 1)
    ) sumLine (
        .clk        (clk),
        .arstN      (arstN),
        .hold       (hold),
        .flushStage ('0),
        .din        (front),
        .stageOut   (stages)
    );

    logic [4:0]        lzCount;
    logic [26:0]       norm;
    logic signed [9:0] expNorm, expRound;
    logic              roundUp;
    logic [24:0]       rounded;

    always_comb begin
        back    = stages[DEPTH-2];
        lzCount = leadZeros(back.mant[26:0]);
        if (back.mant[27]) begin
            norm    = {back.mant[27:2], back.mant[1] | back.mant[0]};
            expNorm = $signed({2'b00, back.exp}) + 10'sd1;
        end else begin
            norm    = back.mant[26:0] << lzCount;
            expNorm = $signed({2'b00, back.exp}) - $signed({5'd0, lzCount});
        end

        // Nearest even on guard, round and sticky
        roundUp  = norm[2] & (norm[1] | norm[0] | norm[3]);
        rounded  = {1'b0, norm[26:3]} + 25'(roundUp);
        expRound = rounded[24] ? expNorm + 10'sd1 : expNorm;

        if (back.special) begin
            sum = back.specialVal;
        end else if (back.mant == 28'd0 || expRound <= 0) begin
            sum = {back.sign, 31'd0};
        end else if (expRound >= 255) begin
            sum = {back.sign, 8'hff, 23'd0};
        end else begin
            sum = {back.sign, expRound[7:0], rounded[22:0]};
        end
    end

endmodule

// File: design/fpMultiplier.sv
`timescale 1ns/1ps

module fpMultiplier import fpExecPkg::*; #(
    parameter int DEPTH = EXEC_DEPTH_DEFAULT
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        hold,
    input  logic [31:0] lhs,
    input  logic [31:0] rhs,
    output logic [31:0] product
);
    typedef struct packed {
        logic        special;
        logic [31:0] specialVal;
        logic        sign;
        logic [9:0]  exp;
        logic [47:0] prod;
    } mulStageT;

    mulStageT    front;
    mulStageT    stages [DEPTH-1];
    mulStageT    back;

    logic        sign, nanAny, infAny, zeroAny;
    logic        nanA, nanB, infA, infB, zeroA, zeroB;
    logic [7:0]  expA, expB;

    always_comb begin
        expA  = lhs[30:23];
        expB  = rhs[30:23];
        sign  = lhs[31] ^ rhs[31];
        nanA  = (expA == 8'hff) && (lhs[22:0] != 23'd0);
        nanB  = (expB == 8'hff) && (rhs[22:0] != 23'd0);
        infA  = (expA == 8'hff) && (lhs[22:0] == 23'd0);
        infB  = (expB == 8'hff) && (rhs[22:0] == 23'd0);
        zeroA = expA == 8'd0;
        zeroB = expB == 8'd0;

        // Infinity times zero is invalid
        nanAny  = nanA || nanB || (infA && zeroB) || (zeroA && infB);
        infAny  = infA || infB;
        zeroAny = zeroA || zeroB;

        front.special = nanAny || infAny || zeroAny;
        if (nanAny) begin
            front.specialVal = CANONICAL_NAN;
        end else if (infAny) begin
            front.specialVal = {sign, 8'hff, 23'd0};
        end else begin
            front.specialVal = {sign, 31'd0};
        end
        front.sign = sign;
        front.exp  = 10'($signed({2'b00, expA}) + $signed({2'b00, expB}) - 10'sd127);
        front.prod = {1'b1, lhs[22:0]} * {1'b1, rhs[22:0]};
    end

    fpDelayLine #(
        .payloadT (mulStageT),
        .DEPTH    (DEPTH - 1)
    ) productLine (
        .clk        (clk),
        .arstN      (arstN),
        .hold       (hold),
        .flushStage ('0),
        .din        (front),
        .stageOut   (stages)
    );

    logic [23:0]       mant;
    logic              guard, sticky, roundUp;
    logic [24:0]       rounded;
    logic signed [9:0] expNorm, expRound;

    always_comb begin
        back = stages[DEPTH-2];
        // Product of two normals lies in [1, 4)
        if (back.prod[47]) begin
            mant    = back.prod[47:24];
            guard   = back.prod[23];
            sticky  = |back.prod[22:0];
            expNorm = $signed(back.exp) + 10'sd1;
        end else begin
            mant    = back.prod[46:23];
            guard   = back.prod[22];
            sticky  = |back.prod[21:0];
            expNorm = $signed(back.exp);
        end

        roundUp  = guard & (sticky | mant[0]);
        rounded  = {1'b0, mant} + 25'(roundUp);
        expRound = rounded[24] ? expNorm + 10'sd1 : expNorm;

        if (back.special) begin
            product = back.specialVal;
        end else if (expRound <= 0) begin
            product = {back.sign, 31'd0};
        end else if (expRound >= 255) begin
            product = {back.sign, 8'hff, 23'd0};
        end else begin
            product = {back.sign, expRound[7:0], rounded[22:0]};
        end
    end

endmodule

// File: design/fpMiscUnit.sv
`timescale 1ns/1ps

module fpMiscUnit import fpExecPkg::*; #(
    parameter int DEPTH = EXEC_DEPTH_DEFAULT
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        hold,
    input  fpuCode      code,
    input  logic [31:0] lhs,
    input  logic [31:0] rhs,
    output logic [31:0] data,
    output logic [4:0]  flags
);
    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  flags;
    } miscStageT;

    miscStageT   front;
    miscStageT   stages [DEPTH-1];

    logic        nanA, nanB, snanA, snanB, anyNan, bothZero;
    logic        lessAB, eqAB, invalid;
    logic [31:0] cleanA, cleanB, keyA, keyB;

    always_comb begin
        nanA  = (lhs[30:23] == 8'hff) && (lhs[22:0] != 23'd0);
        nanB  = (rhs[30:23] == 8'hff) && (rhs[22:0] != 23'd0);
        snanA = nanA && !lhs[22];
        snanB = nanB && !rhs[22];
        anyNan = nanA || nanB;

        // Subnormals compare as signed zero
        cleanA = (lhs[30:23] == 8'd0) ? {lhs[31], 31'd0} : lhs;
        cleanB = (rhs[30:23] == 8'd0) ? {rhs[31], 31'd0} : rhs;

        // Order-preserving keys with -0 below +0
        keyA = cleanA[31] ? ~cleanA : {1'b1, cleanA[30:0]};
        keyB = cleanB[31] ? ~cleanB : {1'b1, cleanB[30:0]};

        lessAB   = keyA < keyB;
        bothZero = (cleanA[30:0] == 31'd0) && (cleanB[30:0] == 31'd0);
        eqAB     = (cleanA == cleanB) || bothZero;

        invalid    = 1'b0;
        front.data = 32'd0;
        case (code)
            FC_SGNJ:  front.data = {rhs[31], lhs[30:0]};
            FC_SGNJN: front.data = {~rhs[31], lhs[30:0]};
            FC_SGNJX: front.data = {lhs[31] ^ rhs[31], lhs[30:0]};
            FC_MIN, FC_MAX: begin
                invalid = snanA || snanB;
                if (nanA && nanB) begin
                    front.data = CANONICAL_NAN;
                end else if (nanA) begin
                    front.data = cleanB;
                end else if (nanB) begin
                    front.data = cleanA;
                end else begin
                    front.data = (lessAB ^ (code == FC_MAX)) ? cleanA : cleanB;
                end
            end
            FC_FEQ: begin
                invalid    = snanA || snanB;
                front.data = {31'd0, !anyNan && eqAB};
            end
            FC_FLT: begin
                invalid    = anyNan;
                front.data = {31'd0, !anyNan && !bothZero && lessAB};
            end
            FC_FLE: begin
                invalid    = anyNan;
                front.data = {31'd0, !anyNan && (lessAB || eqAB)};
            end
            default: front.data = 32'd0;
        endcase

        front.flags = invalid ? FLAG_INVALID : 5'd0;
    end

    fpDelayLine #(
        .payloadT (miscStageT),
        .DEPTH    (DEPTH - 1)
    ) resultLine (
        .clk        (clk),
        .arstN      (arstN),
        .hold       (hold),
        .flushStage ('0),
        .din        (front),
        .stageOut   (stages)
    );

    assign data  = stages[DEPTH-2].data;
    assign flags = stages[DEPTH-2].flags;

endmodule

// File: design/fpExecStage.sv
`timescale 1ns/1ps

module fpExecStage import fpExecPkg::*; #(
    parameter int EXEC_DEPTH = EXEC_DEPTH_DEFAULT
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        stall,
    input  logic        clear,
    input  fpIssueEntry issue,
    input  fpOperand    bypassDataA,
    input  fpOperand    bypassDataB,
    input  fpRecovery   recovery,
    output fpExecResult result,
    output logic        replayValid,
    output robTag       replayTag
);
    // Recovery hits on flushAll or a tag in [headTag, tailTag) modulo wrap
    function automatic logic flushHit(fpRecovery rec, robTag tag);
        logic inRange;
        if (rec.headTag <= rec.tailTag) begin
            inRange = (tag >= rec.headTag) && (tag < rec.tailTag);
        end else begin
            inRange = (tag >= rec.headTag) || (tag < rec.tailTag);
        end
        return rec.active && (rec.flushAll || inRange);
    endfunction

    fpIssueEntry           inReg;
    fpOperand              opA, opB;
    logic                  regValid;
    logic                  pipeHold;
    logic [EXEC_DEPTH-1:0] flushVec;
    logic [EXEC_DEPTH-2:0] tagFlush;
    fpTagEntry             tagIn;
    fpTagEntry             tagStage [EXEC_DEPTH-1];
    fpTagEntry             lastTag;
    logic [31:0]           addData, mulData, miscData;
    logic [4:0]            miscFlags;

    // Stage 0, the input register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inReg <= '0;
        end else if (clear) begin
            inReg.valid <= 1'b0;
        end else if (!stall) begin
            inReg <= issue;
        end
    end

    // Clear wins over stall so every stage empties on the same edge
    assign pipeHold = stall && !clear;

    always_comb begin
        opA      = inReg.bypassA ? bypassDataA : inReg.operandA;
        opB      = inReg.bypassB ? bypassDataB : inReg.operandB;
        regValid = (!inReg.srcRegA || opA.valid) && (!inReg.srcRegB || opB.valid);

        flushVec[0] = flushHit(recovery, inReg.tag);
        for (int j = 1; j < EXEC_DEPTH; j++) begin
            flushVec[j] = flushHit(recovery, tagStage[j-1].tag);
        end
        tagFlush = flushVec[EXEC_DEPTH-2:0] | {(EXEC_DEPTH-1){clear}};

        tagIn.valid    = inReg.valid;
        tagIn.regValid = regValid;
        tagIn.tag      = inReg.tag;
        tagIn.code     = inReg.code;
    end

    fpDelayLine #(
        .payloadT (fpTagEntry),
        .DEPTH    (EXEC_DEPTH - 1)
    ) tagLine (
        .clk        (clk),
        .arstN      (arstN),
        .hold       (pipeHold),
        .flushStage (tagFlush),
        .din        (tagIn),
        .stageOut   (tagStage)
    );

    fpAdder #(.DEPTH(EXEC_DEPTH)) adder0 (
        .clk      (clk),
        .arstN    (arstN),
        .hold     (pipeHold),
        .lhs      (opA.data),
        .rhs      (opB.data),
        .subtract (inReg.code == FC_SUB),
        .sum      (addData)
    );

    fpMultiplier #(.DEPTH(EXEC_DEPTH)) multiplier0 (
        .clk     (clk),
        .arstN   (arstN),
        .hold    (pipeHold),
        .lhs     (opA.data),
        .rhs     (opB.data),
        .product (mulData)
    );

    fpMiscUnit #(.DEPTH(EXEC_DEPTH)) misc0 (
        .clk   (clk),
        .arstN (arstN),
        .hold  (pipeHold),
        .code  (inReg.code),
        .lhs   (opA.data),
        .rhs   (opB.data),
        .data  (miscData),
        .flags (miscFlags)
    );

    always_comb begin
        lastTag = tagStage[EXEC_DEPTH-2];

        result.valid = !stall && !clear && !flushVec[EXEC_DEPTH-1]
                       && lastTag.valid && lastTag.regValid;
        result.tag   = lastTag.tag;
        result.code  = lastTag.code;
        case (unitOf(lastTag.code))
            UNIT_ADDER: begin
                result.data  = addData;
                result.flags = 5'd0;
            end
            UNIT_MULTIPLIER: begin
                result.data  = mulData;
                result.flags = 5'd0;
            end
            default: begin
                result.data  = miscData;
                result.flags = miscFlags;
            end
        endcase

        // Replay goes out one stage after the operand read
        replayValid = !stall && !clear && !flushVec[1]
                      && tagStage[0].valid && !tagStage[0].regValid;
        replayTag   = tagStage[0].tag;
    end

endmodule

// File: tb/fpExecStageTb.sv
`timescale 1ns/1ps

module fpExecStageTb import fpExecPkg::*; ();

    localparam int PERIOD      = 8;
    localparam int DEPTH       = 3;
    localparam int NUM_VECTORS = 37;
    localparam int FIELDS      = 11;
    // Leading ops go in back to back with no stall
    localparam int STEADY_OPS  = 10;
    localparam int DRAIN_LIMIT = 40;

    typedef struct packed {
        fpExecResult res;
        logic [31:0] liveAt;
    } pendingT;

    logic        clk;
    logic        arstN;
    logic        stall;
    logic        clear;
    fpIssueEntry issue;
    fpOperand    bypassDataA;
    fpOperand    bypassDataB;
    fpRecovery   recovery;
    fpExecResult result;
    logic        replayValid;
    robTag       replayTag;

    logic [31:0] vectors [NUM_VECTORS*FIELDS];
    pendingT     resultQ [$];
    pendingT     replayQ [$];
    fpOperand    heldBypassA;
    fpOperand    heldBypassB;
    logic [31:0] lfsrState;
    int          liveEdges;
    int          valueErrors;
    int          otherErrors;
    int          resultsSeen;
    int          replaysSeen;

    fpExecStage #(.EXEC_DEPTH(DEPTH)) dut0 (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .clear       (clear),
        .issue       (issue),
        .bypassDataA (bypassDataA),
        .bypassDataB (bypassDataB),
        .recovery    (recovery),
        .result      (result),
        .replayValid (replayValid),
        .replayTag   (replayTag)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #((NUM_VECTORS * 4 + 50) * PERIOD);
        $display("Timeout: the run did not finish within %0d clock periods",
                 NUM_VECTORS * 4 + 50);
        $display("Test failures found");
        $finish;
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic nextRandomBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    // One cycle in four on average
    function automatic logic pickStall();
        logic b0;
        logic b1;
        b0 = nextRandomBit();
        b1 = nextRandomBit();
        return b0 && b1;
    endfunction

    // Distance from head, modulo the tag space, below the range length
    function automatic logic inRecovery(fpRecovery rec, robTag tag);
        robTag offset;
        robTag span;
        offset = tag - rec.headTag;
        span   = rec.tailTag - rec.headTag;
        return rec.active && (rec.flushAll || offset < span);
    endfunction

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %0h, expected %0h at %0t", name, actual, expected,
                     $time);
            valueErrors++;
        end
    endtask

    task automatic dropFlushed(input fpRecovery rec);
        for (int i = resultQ.size() - 1; i >= 0; i--) begin
            if (inRecovery(rec, resultQ[i].res.tag)) begin
                resultQ.delete(i);
            end
        end
        for (int i = replayQ.size() - 1; i >= 0; i--) begin
            if (inRecovery(rec, replayQ[i].res.tag)) begin
                replayQ.delete(i);
            end
        end
    endtask

    task automatic checkOutputs(input logic stalled);
        pendingT entry;
        if (stalled) begin
            checkValue("result.valid", result.valid, 1'b0);
            checkValue("replayValid", replayValid, 1'b0);
        end
        if (result.valid) begin
            if (resultQ.size() == 0) begin
                $display("Result with tag %0h came out while none was expected", result.tag);
                otherErrors++;
            end else begin
                entry = resultQ.pop_front();
                checkValue("result.tag", result.tag, entry.res.tag);
                checkValue("result.code", result.code, entry.res.code);
                checkValue("result.data", result.data, entry.res.data);
                checkValue("result.flags", result.flags, entry.res.flags);
                checkValue("result latency", liveEdges - entry.liveAt, DEPTH);
                resultsSeen++;
            end
        end
        if (replayValid) begin
            if (replayQ.size() == 0) begin
                $display("Replay of tag %0h came out while none was expected", replayTag);
                otherErrors++;
            end else begin
                entry = replayQ.pop_front();
                checkValue("replayTag", replayTag, entry.res.tag);
                checkValue("replay latency", liveEdges - entry.liveAt, DEPTH - 1);
                replaysSeen++;
            end
        end
    endtask

    // One clock cycle, idx below zero drives no op
    task automatic runCycle(input int idx, input logic stalled);
        int          base;
        logic [31:0] ctrl;
        pendingT     entry;
        base = idx * FIELDS;
        ctrl = '0;
        @(negedge clk);
        stall       = stalled;
        issue       = '0;
        recovery    = '0;
        bypassDataA = heldBypassA;
        bypassDataB = heldBypassB;
        if (idx >= 0) begin
            ctrl           = vectors[base+2];
            issue.valid    = 1'b1;
            issue.code     = fpuCode'(vectors[base][3:0]);
            issue.tag      = vectors[base+1][5:0];
            issue.srcRegA  = ctrl[0];
            issue.srcRegB  = ctrl[1];
            issue.bypassA  = ctrl[2];
            issue.bypassB  = ctrl[3];
            issue.operandA = {ctrl[4], vectors[base+3]};
            issue.operandB = {ctrl[5], vectors[base+4]};
            recovery       = vectors[base+7][13:0];
            // Recovery hits the ops already captured, not the one on the port
            dropFlushed(recovery);
            entry.res    = {1'b1, issue.tag, issue.code, vectors[base+8], vectors[base+9][4:0]};
            entry.liveAt = liveEdges;
            if (vectors[base+10][0]) begin
                replayQ.push_back(entry);
            end else begin
                resultQ.push_back(entry);
            end
        end
        #2;
        checkOutputs(stalled);
        if (!stalled) begin
            liveEdges++;
        end
        // Bypass values belong to the op sitting in the input register
        if (idx >= 0) begin
            heldBypassA = {ctrl[6], vectors[base+5]};
            heldBypassB = {ctrl[7], vectors[base+6]};
        end
    endtask

    initial begin
        int drained;
        arstN       = 1'b0;
        stall       = 1'b0;
        clear       = 1'b0;
        issue       = '0;
        bypassDataA = '0;
        bypassDataB = '0;
        recovery    = '0;
        heldBypassA = '0;
        heldBypassB = '0;
        lfsrState   = 32'h7aaf;
        liveEdges   = 0;
        valueErrors = 0;
        otherErrors = 0;
        resultsSeen = 0;
        replaysSeen = 0;
        $readmemh("tb/fpExecVectors.txt", vectors);

        repeat (3) @(posedge clk);
        @(negedge clk);
        checkValue("result.valid", result.valid, 1'b0);
        checkValue("replayValid", replayValid, 1'b0);
        arstN = 1'b1;

        for (int i = 0; i < NUM_VECTORS; i++) begin
            while (i >= STEADY_OPS && pickStall()) begin
                runCycle(-1, 1'b1);
            end
            runCycle(i, 1'b0);
        end

        drained = 0;
        while ((resultQ.size() > 0 || replayQ.size() > 0) && drained < DRAIN_LIMIT) begin
            runCycle(-1, pickStall());
            drained++;
        end
        // Idle cycles catch stray results
        repeat (4) begin
            runCycle(-1, 1'b0);
        end
        if (resultQ.size() > 0 || replayQ.size() > 0) begin
            $display("%0d results and %0d replays never came out", resultQ.size(),
                     replayQ.size());
            otherErrors++;
        end

        $display("Summary: %0d value mismatches, %0d other errors, %0d results, %0d replays",
                 valueErrors, otherErrors, resultsSeen, replaysSeen);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: fpExecStage.f
design/fpExecPkg.sv
design/fpDelayLine.sv
design/fpAdder.sv
design/fpMultiplier.sv
design/fpMiscUnit.sv
design/fpExecStage.sv
tb/fpExecStageTb.sv

// File: tb/fpExecVectors.txt
// code tag ctrl opA opB bypassA bypassB recovery expData expFlags expReplay
// ctrl bits: 0 srcRegA, 1 srcRegB, 2 bypassA, 3 bypassB, 4/5 operand valid, 6/7 bypass valid
0 01 33 3f800000 40000000 00000000 00000000 0000 40400000 00 0
1 02 33 3f800000 3f800000 00000000 00000000 0000 00000000 00 0
2 03 33 3fc00000 40000000 00000000 00000000 0000 40400000 00 0
0 04 33 7f800000 ff800000 00000000 00000000 0000 7fc00000 00 0
2 05 33 7f000000 40000000 00000000 00000000 0000 7f800000 00 0
2 06 33 80800000 00800000 00000000 00000000 0000 80000000 00 0
0 07 33 00000001 3f800000 00000000 00000000 0000 3f800000 00 0
0 08 33 3f800000 33800000 00000000 00000000 0000 3f800000 00 0
0 09 33 3f800001 33800000 00000000 00000000 0000 3f800002 00 0
1 0a 33 40a00000 40400000 00000000 00000000 0000 40000000 00 0
2 0b 33 00000000 7f800000 00000000 00000000 0000 7fc00000 00 0
0 0c 33 7f7fffff 7f7fffff 00000000 00000000 0000 7f800000 00 0
3 0d 33 3f800000 bf800000 00000000 00000000 0000 bf800000 00 0
4 0e 33 3f800000 bf800000 00000000 00000000 0000 3f800000 00 0
5 0f 33 bf800000 bf800000 00000000 00000000 0000 3f800000 00 0
6 10 33 00000000 80000000 00000000 00000000 0000 80000000 00 0
7 11 33 80000000 00000000 00000000 00000000 0000 00000000 00 0
6 12 33 7fc00000 40000000 00000000 00000000 0000 40000000 00 0
7 13 33 7f800001 3f800000 00000000 00000000 0000 3f800000 10 0
8 14 33 3f800000 3f800000 00000000 00000000 0000 00000001 00 0
8 15 33 7f800001 3f800000 00000000 00000000 0000 00000000 10 0
9 16 33 7fc00000 3f800000 00000000 00000000 0000 00000000 10 0
a 17 33 80000000 00000000 00000000 00000000 0000 00000001 00 0
0 18 23 3f800000 3f800000 00000000 00000000 0000 00000000 00 1
0 19 67 3f800000 3f800000 40000000 00000000 0000 40400000 00 0
0 1a 3b 3f800000 3f800000 00000000 00000000 0000 00000000 00 1
0 1b 33 3f800000 3f800000 00000000 00000000 0000 40000000 00 0
0 1c 33 40000000 40000000 00000000 00000000 0000 40800000 00 0
0 1d 33 40400000 3f800000 00000000 00000000 0000 40800000 00 0
0 1e 33 40800000 3f800000 00000000 00000000 271e 40a00000 00 0
0 1f 33 3f800000 3f800000 00000000 00000000 0000 40000000 00 0
0 20 33 3f800000 3f800000 00000000 00000000 0000 40000000 00 0
0 21 33 3f800000 3f800000 00000000 00000000 0000 40000000 00 0
2 22 33 3fc00000 3fc00000 00000000 00000000 3000 40100000 00 0
0 3e 33 3f800000 40000000 00000000 00000000 0000 40400000 00 0
1 3f 33 40000000 3f800000 00000000 00000000 0000 3f800000 00 0
7 00 33 3f800000 40000000 00000000 00000000 2fc1 40000000 00 0
